/* hdl/tcm_pkg.sv */
////////////////////////////////////////////////////////////
// Address map of the private bus. Both TCM sizes must be
// powers of two and the windows must be size aligned
////////////////////////////////////////////////////////////

package tcm_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;  // Byte address
  localparam int unsigned DATA_W = 32;  // One word per beat
  localparam int unsigned BE_W   = DATA_W / 8;

  ////////////////////////////////////////////////////////////
  // Internal address space
  ////////////////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] INT_BUS_START = 32'h7000_0000;

  // Instruction TCM sits at the very start of the space
  localparam logic [ADDR_W-1:0] ITCM_START = INT_BUS_START;
  localparam logic [ADDR_W-1:0] ITCM_SIZE  = 32'h0000_1000;  // 4 KiB

  // Data TCM leaves a hole of 4 KiB after the ITCM
  localparam logic [ADDR_W-1:0] DTCM_START = INT_BUS_START + 32'h2000;
  localparam logic [ADDR_W-1:0] DTCM_SIZE  = 32'h0000_1000;  // 4 KiB

  localparam int unsigned ITCM_WORDS = ITCM_SIZE / 4;  // 1024 words
  localparam int unsigned DTCM_WORDS = DTCM_SIZE / 4;  // 1024 words
  localparam int unsigned TCM_IDX_W  = $clog2(ITCM_WORDS);  // Same for both TCMs

  ////////////////////////////////////////////////////////////
  // Router limits
  ////////////////////////////////////////////////////////////

  // Requests in flight per router, no response yet
  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam int unsigned CNT_W           = $clog2(MAX_OUTSTANDING + 1);

  // Decoded slave of one request
  typedef enum logic [1:0] {
    TGT_EXT  = 2'd0,  // Anything outside the TCM windows
    TGT_ITCM = 2'd1,
    TGT_DTCM = 2'd2
  } target_e;

endpackage

/* hdl/instr_router.sv */
////////////////////////////////////////////////////////////
// Fetch router. In-order only, a target switch waits until
// every earlier request of this host has been answered
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_router import tcm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Fetch host
  input  logic              fetch_req_i,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  output logic              fetch_gnt_o,
  output logic              fetch_rvalid_o,
  output logic [DATA_W-1:0] fetch_rdata_o,
  output logic              fetch_err_o,
  // External instruction memory
  output logic              ext_req_o,
  output logic [ADDR_W-1:0] ext_addr_o,
  input  logic              ext_gnt_i,
  input  logic              ext_rvalid_i,
  input  logic [DATA_W-1:0] ext_rdata_i,
  input  logic              ext_err_i,
  // ITCM port B
  output logic              itcm_req_o,
  output logic [TCM_IDX_W-1:0] itcm_idx_o,
  input  logic              itcm_rvalid_i,
  input  logic [DATA_W-1:0] itcm_rdata_i
);

  logic [CNT_W-1:0] cnt_q;       // Accepted, not yet answered
  target_e          last_tgt_q;  // Target of newest accept
  target_e          tgt;         // Decode of the current address
  logic             slot_ok;     // Room and same target
  logic             accept;

  // Window match with the offset bits masked off
  assign tgt = ((fetch_addr_i & ~(ITCM_SIZE - 1)) == ITCM_START) ? TGT_ITCM : TGT_EXT;

  assign slot_ok = (cnt_q < CNT_W'(MAX_OUTSTANDING)) &&
                   ((cnt_q == '0) || (tgt == last_tgt_q));

  // Slave requests never look at ext_gnt_i, no loop through the memory
  assign ext_req_o   = fetch_req_i && slot_ok && (tgt == TGT_EXT);
  assign itcm_req_o  = fetch_req_i && slot_ok && (tgt == TGT_ITCM);
  assign fetch_gnt_o = slot_ok && ((tgt != TGT_EXT) || ext_gnt_i);
  assign accept      = fetch_req_i && fetch_gnt_o;

  assign ext_addr_o = fetch_addr_i;
  assign itcm_idx_o = fetch_addr_i[TCM_IDX_W+1:2];  // Word index

  // All pending requests share last_tgt_q
  always_comb begin
    if (last_tgt_q == TGT_ITCM) begin
      fetch_rvalid_o = itcm_rvalid_i;
      fetch_rdata_o  = itcm_rdata_i;
      fetch_err_o    = 1'b0;  // TCM never fails
    end else begin
      fetch_rvalid_o = ext_rvalid_i;
      fetch_rdata_o  = ext_rdata_i;
      fetch_err_o    = ext_err_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= '0;
      last_tgt_q <= TGT_EXT;
    end else begin
      case ({accept, fetch_rvalid_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // None or both
      endcase
      if (accept) begin
        last_tgt_q <= tgt;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // A slave answering with nothing pending breaks the order
  a_no_orphan_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_rvalid_o |-> (cnt_q != '0));

  a_cnt_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= CNT_W'(MAX_OUTSTANDING));

endmodule

/* hdl/data_router.sv */
////////////////////////////////////////////////////////////
// Load/store router over ITCM, DTCM and external memory.
// Writes are answered with one rvalid like reads
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module data_router import tcm_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Data host
  input  logic                 data_req_i,
  input  logic                 data_we_i,
  input  logic [ADDR_W-1:0]    data_addr_i,
  input  logic [BE_W-1:0]      data_be_i,
  input  logic [DATA_W-1:0]    data_wdata_i,
  output logic                 data_gnt_o,
  output logic                 data_rvalid_o,
  output logic                 data_err_o,
  output logic [DATA_W-1:0]    data_rdata_o,
  // External data memory
  output logic                 ext_req_o,
  output logic                 ext_we_o,
  output logic [ADDR_W-1:0]    ext_addr_o,
  output logic [BE_W-1:0]      ext_be_o,
  output logic [DATA_W-1:0]    ext_wdata_o,
  input  logic                 ext_gnt_i,
  input  logic                 ext_rvalid_i,
  input  logic                 ext_err_i,
  input  logic [DATA_W-1:0]    ext_rdata_i,
  // ITCM port A
  output logic                 itcm_req_o,
  output logic                 itcm_we_o,
  output logic [TCM_IDX_W-1:0] itcm_idx_o,
  output logic [BE_W-1:0]      itcm_be_o,
  output logic [DATA_W-1:0]    itcm_wdata_o,
  input  logic                 itcm_rvalid_i,
  input  logic [DATA_W-1:0]    itcm_rdata_i,
  // DTCM
  output logic                 dtcm_req_o,
  output logic                 dtcm_we_o,
  output logic [TCM_IDX_W-1:0] dtcm_idx_o,
  output logic [BE_W-1:0]      dtcm_be_o,
  output logic [DATA_W-1:0]    dtcm_wdata_o,
  input  logic                 dtcm_rvalid_i,
  input  logic [DATA_W-1:0]    dtcm_rdata_i
);

  logic [CNT_W-1:0] cnt_q;
  target_e          last_tgt_q;
  target_e          tgt;
  logic             slot_ok;
  logic             accept;

  ////////////////////////////////////////////////////////////
  // Decode and grant
  ////////////////////////////////////////////////////////////

  always_comb begin
    if ((data_addr_i & ~(ITCM_SIZE - 1)) == ITCM_START) begin
      tgt = TGT_ITCM;
    end else if ((data_addr_i & ~(DTCM_SIZE - 1)) == DTCM_START) begin
      tgt = TGT_DTCM;
    end else begin
      tgt = TGT_EXT;  // Hole and outside space both go out
    end
  end

  assign slot_ok = (cnt_q < CNT_W'(MAX_OUTSTANDING)) &&
                   ((cnt_q == '0) || (tgt == last_tgt_q));

  assign ext_req_o  = data_req_i && slot_ok && (tgt == TGT_EXT);
  assign itcm_req_o = data_req_i && slot_ok && (tgt == TGT_ITCM);
  assign dtcm_req_o = data_req_i && slot_ok && (tgt == TGT_DTCM);
  assign data_gnt_o = slot_ok && ((tgt != TGT_EXT) || ext_gnt_i);
  assign accept     = data_req_i && data_gnt_o;

  // Payload fans out to every slave, only req is steered
  assign ext_we_o     = data_we_i;
  assign ext_addr_o   = data_addr_i;
  assign ext_be_o     = data_be_i;
  assign ext_wdata_o  = data_wdata_i;
  assign itcm_we_o    = data_we_i;
  assign itcm_idx_o   = data_addr_i[TCM_IDX_W+1:2];
  assign itcm_be_o    = data_be_i;
  assign itcm_wdata_o = data_wdata_i;
  assign dtcm_we_o    = data_we_i;
  assign dtcm_idx_o   = data_addr_i[TCM_IDX_W+1:2];
  assign dtcm_be_o    = data_be_i;
  assign dtcm_wdata_o = data_wdata_i;

  ////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////

  always_comb begin
    data_err_o = 1'b0;  // TCMs never fail
    case (last_tgt_q)
      TGT_ITCM: begin
        data_rvalid_o = itcm_rvalid_i;
        data_rdata_o  = itcm_rdata_i;
      end
      TGT_DTCM: begin
        data_rvalid_o = dtcm_rvalid_i;
        data_rdata_o  = dtcm_rdata_i;
      end
      default: begin
        data_rvalid_o = ext_rvalid_i;
        data_rdata_o  = ext_rdata_i;
        data_err_o    = ext_err_i;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= '0;
      last_tgt_q <= TGT_EXT;
    end else begin
      case ({accept, data_rvalid_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
      if (accept) begin
        last_tgt_q <= tgt;
      end
    end
  end

  a_no_orphan_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_rvalid_o |-> (cnt_q != '0));

  a_cnt_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= CNT_W'(MAX_OUTSTANDING));

endmodule

/* hdl/itcm.sv */
////////////////////////////////////////////////////////////
// Instruction TCM, one cycle read latency on both ports.
// Same-word collision returns the old word on port B
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module itcm import tcm_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Port A, load/store side
  input  logic                 a_req_i,
  input  logic                 a_we_i,
  input  logic [TCM_IDX_W-1:0] a_idx_i,
  input  logic [BE_W-1:0]      a_be_i,
  input  logic [DATA_W-1:0]    a_wdata_i,
  output logic                 a_rvalid_o,
  output logic [DATA_W-1:0]    a_rdata_o,
  // Port B, fetch side
  input  logic                 b_req_i,
  input  logic [TCM_IDX_W-1:0] b_idx_i,
  output logic                 b_rvalid_o,
  output logic [DATA_W-1:0]    b_rdata_o
);

  logic [DATA_W-1:0] mem_q [ITCM_WORDS];

  // Port A write and read
  always_ff @(posedge clk_i) begin
    if (a_req_i) begin
      a_rdata_o <= mem_q[a_idx_i];  // Old word, also on writes
      if (a_we_i) begin
        for (int i = 0; i < BE_W; i++) begin
          if (a_be_i[i]) begin
            mem_q[a_idx_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
          end
        end
      end
    end
  end

  // Port B read only
  always_ff @(posedge clk_i) begin
    if (b_req_i) begin
      b_rdata_o <= mem_q[b_idx_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_rvalid_o <= 1'b0;
      b_rvalid_o <= 1'b0;
    end else begin
      a_rvalid_o <= a_req_i;  // Reads and writes alike
      b_rvalid_o <= b_req_i;
    end
  end

endmodule

/* hdl/dtcm.sv */
////////////////////////////////////////////////////////////
// Data TCM, single port, response one cycle after req
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dtcm import tcm_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 a_req_i,
  input  logic                 a_we_i,
  input  logic [TCM_IDX_W-1:0] a_idx_i,
  input  logic [BE_W-1:0]      a_be_i,
  input  logic [DATA_W-1:0]    a_wdata_i,
  output logic                 a_rvalid_o,
  output logic [DATA_W-1:0]    a_rdata_o
);

  logic [DATA_W-1:0] mem_q [DTCM_WORDS];

  always_ff @(posedge clk_i) begin
    if (a_req_i) begin
      a_rdata_o <= mem_q[a_idx_i];
      if (a_we_i) begin
        for (int i = 0; i < BE_W; i++) begin
          if (a_be_i[i]) begin
            mem_q[a_idx_i][8*i +: 8] <= a_wdata_i[8*i +: 8];  // Enabled lanes only
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_rvalid_o <= 1'b0;
    end else begin
      a_rvalid_o <= a_req_i;
    end
  end

endmodule

/* hdl/tcm_subsystem.sv */
////////////////////////////////////////////////////////////
// Private bus of the core. External ports must answer each
// granted request once, in order, at least a cycle later
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tcm_subsystem import tcm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Fetch host
  input  logic              fetch_req_i,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  output logic              fetch_gnt_o,
  output logic              fetch_rvalid_o,
  output logic [DATA_W-1:0] fetch_rdata_o,
  output logic              fetch_err_o,
  // Data host
  input  logic              data_req_i,
  input  logic              data_we_i,
  input  logic [ADDR_W-1:0] data_addr_i,
  input  logic [BE_W-1:0]   data_be_i,
  input  logic [DATA_W-1:0] data_wdata_i,
  output logic              data_gnt_o,
  output logic              data_rvalid_o,
  output logic              data_err_o,
  output logic [DATA_W-1:0] data_rdata_o,
  // External instruction memory
  output logic              ext_instr_req_o,
  output logic [ADDR_W-1:0] ext_instr_addr_o,
  input  logic              ext_instr_gnt_i,
  input  logic              ext_instr_rvalid_i,
  input  logic [DATA_W-1:0] ext_instr_rdata_i,
  input  logic              ext_instr_err_i,
  // External data memory
  output logic              ext_data_req_o,
  output logic              ext_data_we_o,
  output logic [ADDR_W-1:0] ext_data_addr_o,
  output logic [BE_W-1:0]   ext_data_be_o,
  output logic [DATA_W-1:0] ext_data_wdata_o,
  input  logic              ext_data_gnt_i,
  input  logic              ext_data_rvalid_i,
  input  logic [DATA_W-1:0] ext_data_rdata_i,
  input  logic              ext_data_err_i
);

  // Fetch router to ITCM port B
  logic                 if_itcm_req;
  logic [TCM_IDX_W-1:0] if_itcm_idx;
  logic                 if_itcm_rvalid;
  logic [DATA_W-1:0]    if_itcm_rdata;

  // Data router to ITCM port A
  logic                 ls_itcm_req, ls_itcm_we;
  logic [TCM_IDX_W-1:0] ls_itcm_idx;
  logic [BE_W-1:0]      ls_itcm_be;
  logic [DATA_W-1:0]    ls_itcm_wdata;
  logic                 ls_itcm_rvalid;
  logic [DATA_W-1:0]    ls_itcm_rdata;

  // Data router to DTCM
  logic                 ls_dtcm_req, ls_dtcm_we;
  logic [TCM_IDX_W-1:0] ls_dtcm_idx;
  logic [BE_W-1:0]      ls_dtcm_be;
  logic [DATA_W-1:0]    ls_dtcm_wdata;
  logic                 ls_dtcm_rvalid;
  logic [DATA_W-1:0]    ls_dtcm_rdata;

  ////////////////////////////////////////////////////////////
  // Routers
  ////////////////////////////////////////////////////////////

  instr_router u_instr_router (
    .clk_i, .rst_n_i,
    .fetch_req_i, .fetch_addr_i, .fetch_gnt_o,
    .fetch_rvalid_o, .fetch_rdata_o, .fetch_err_o,
    .ext_req_o    (ext_instr_req_o),
    .ext_addr_o   (ext_instr_addr_o),
    .ext_gnt_i    (ext_instr_gnt_i),
    .ext_rvalid_i (ext_instr_rvalid_i),
    .ext_rdata_i  (ext_instr_rdata_i),
    .ext_err_i    (ext_instr_err_i),
    .itcm_req_o   (if_itcm_req),
    .itcm_idx_o   (if_itcm_idx),
    .itcm_rvalid_i(if_itcm_rvalid),
    .itcm_rdata_i (if_itcm_rdata)
  );

  data_router u_data_router (
    .clk_i, .rst_n_i,
    .data_req_i, .data_we_i, .data_addr_i, .data_be_i, .data_wdata_i,
    .data_gnt_o, .data_rvalid_o, .data_err_o, .data_rdata_o,
    .ext_req_o    (ext_data_req_o),
    .ext_we_o     (ext_data_we_o),
    .ext_addr_o   (ext_data_addr_o),
    .ext_be_o     (ext_data_be_o),
    .ext_wdata_o  (ext_data_wdata_o),
    .ext_gnt_i    (ext_data_gnt_i),
    .ext_rvalid_i (ext_data_rvalid_i),
    .ext_err_i    (ext_data_err_i),
    .ext_rdata_i  (ext_data_rdata_i),
    .itcm_req_o   (ls_itcm_req),
    .itcm_we_o    (ls_itcm_we),
    .itcm_idx_o   (ls_itcm_idx),
    .itcm_be_o    (ls_itcm_be),
    .itcm_wdata_o (ls_itcm_wdata),
    .itcm_rvalid_i(ls_itcm_rvalid),
    .itcm_rdata_i (ls_itcm_rdata),
    .dtcm_req_o   (ls_dtcm_req),
    .dtcm_we_o    (ls_dtcm_we),
    .dtcm_idx_o   (ls_dtcm_idx),
    .dtcm_be_o    (ls_dtcm_be),
    .dtcm_wdata_o (ls_dtcm_wdata),
    .dtcm_rvalid_i(ls_dtcm_rvalid),
    .dtcm_rdata_i (ls_dtcm_rdata)
  );

  ////////////////////////////////////////////////////////////
  // Memories
  ////////////////////////////////////////////////////////////

  // Shared by both routers, one port each
  itcm u_itcm (
    .clk_i, .rst_n_i,
    .a_req_i   (ls_itcm_req),
    .a_we_i    (ls_itcm_we),
    .a_idx_i   (ls_itcm_idx),
    .a_be_i    (ls_itcm_be),
    .a_wdata_i (ls_itcm_wdata),
    .a_rvalid_o(ls_itcm_rvalid),
    .a_rdata_o (ls_itcm_rdata),
    .b_req_i   (if_itcm_req),
    .b_idx_i   (if_itcm_idx),
    .b_rvalid_o(if_itcm_rvalid),
    .b_rdata_o (if_itcm_rdata)
  );

  dtcm u_dtcm (
    .clk_i, .rst_n_i,
    .a_req_i   (ls_dtcm_req),
    .a_we_i    (ls_dtcm_we),
    .a_idx_i   (ls_dtcm_idx),
    .a_be_i    (ls_dtcm_be),
    .a_wdata_i (ls_dtcm_wdata),
    .a_rvalid_o(ls_dtcm_rvalid),
    .a_rdata_o (ls_dtcm_rdata)
  );

endmodule

/* verif/ext_mem_model.sv */
////////////////////////////////////////////////////////////
// External memory stand-in. Writes are not stored, every
// answer is a fixed function of the request address
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ext_mem_model import tcm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o
);

  logic [ADDR_W-1:0] addr_q [$];  // Granted, not yet answered
  int                due_q [$];   // Answer cycle per entry
  int                cycle;
  int                last_due;
  int                due;
  logic [ADDR_W-1:0] resp_addr;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      cycle    = 0;
      last_due = 0;
      addr_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      if (req_i && gnt_o) begin
        due = cycle + int'($urandom_range(1, 5));  // 1 to 5 cycles
        if (due <= last_due) begin
          due = last_due + 1;  // In order, one answer per cycle
        end
        last_due = due;
        addr_q.push_back(addr_i);
        due_q.push_back(due);
      end
      gnt_o    <= ($urandom_range(0, 3) != 0);  // About 3 cycles in 4
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        resp_addr = addr_q.pop_front();
        void'(due_q.pop_front());
        rvalid_o <= 1'b1;
        rdata_o  <= {resp_addr[15:0], resp_addr[31:16]} ^ 32'h3c5a_96e1;
        err_o    <= (resp_addr[7:0] == 8'hEE);  // Injected bus error
      end
    end
  end

endmodule

/* verif/tb_tcm_subsystem.sv */
////////////////////////////////////////////////////////////
// Testbench of the private bus. TCM reads only touch words
// written earlier, unwritten TCM words are never checked
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_tcm_subsystem import tcm_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int N_WORDS      = 32;   // TCM words in use per TCM
  localparam int N_PARTIAL    = 64;
  localparam int N_EXT        = 24;
  localparam int N_MIXED      = 160;  // Per host
  localparam int N_TXN        = 5 * N_WORDS + N_PARTIAL + 2 * N_EXT + 2 * N_MIXED;
  localparam int WATCHDOG_NS  = (N_TXN * 20 + RESET_CYCLES) * CLK_PERIOD;

  typedef struct packed {
    logic              rd;     // Compare rdata, reads only
    logic              err;
    logic [DATA_W-1:0] rdata;
  } resp_t;

  logic clk = 1'b0;
  logic rst_n;
  logic fetch_req, fetch_gnt, fetch_rvalid, fetch_err;
  logic [ADDR_W-1:0] fetch_addr;
  logic [DATA_W-1:0] fetch_rdata;
  logic data_req, data_we, data_gnt, data_rvalid, data_err;
  logic [ADDR_W-1:0] data_addr;
  logic [BE_W-1:0]   data_be;
  logic [DATA_W-1:0] data_wdata, data_rdata;
  logic ei_req, ei_gnt, ei_rvalid, ei_err;  // External instruction port
  logic [ADDR_W-1:0] ei_addr;
  logic [DATA_W-1:0] ei_rdata;
  logic ed_req, ed_we, ed_gnt, ed_rvalid, ed_err;  // External data port
  logic [ADDR_W-1:0] ed_addr;
  logic [BE_W-1:0]   ed_be;
  logic [DATA_W-1:0] ed_wdata, ed_rdata;

  logic [DATA_W-1:0] itcm_shadow [ITCM_WORDS];
  logic [DATA_W-1:0] dtcm_shadow [DTCM_WORDS];
  resp_t fetch_q [$];  // Expected, in acceptance order
  resp_t data_q [$];
  int checks = 0;
  int errors = 0;
  int checks_at_start = 0;
  int errors_at_start = 0;
  bit idle_check;

  always #(CLK_PERIOD / 2) clk = ~clk;

  tcm_subsystem tcm_subsystem_inst (
    .clk_i(clk), .rst_n_i(rst_n),
    .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr), .fetch_gnt_o(fetch_gnt),
    .fetch_rvalid_o(fetch_rvalid), .fetch_rdata_o(fetch_rdata), .fetch_err_o(fetch_err),
    .data_req_i(data_req), .data_we_i(data_we), .data_addr_i(data_addr),
    .data_be_i(data_be), .data_wdata_i(data_wdata), .data_gnt_o(data_gnt),
    .data_rvalid_o(data_rvalid), .data_err_o(data_err), .data_rdata_o(data_rdata),
    .ext_instr_req_o(ei_req), .ext_instr_addr_o(ei_addr), .ext_instr_gnt_i(ei_gnt),
    .ext_instr_rvalid_i(ei_rvalid), .ext_instr_rdata_i(ei_rdata), .ext_instr_err_i(ei_err),
    .ext_data_req_o(ed_req), .ext_data_we_o(ed_we), .ext_data_addr_o(ed_addr),
    .ext_data_be_o(ed_be), .ext_data_wdata_o(ed_wdata), .ext_data_gnt_i(ed_gnt),
    .ext_data_rvalid_i(ed_rvalid), .ext_data_rdata_i(ed_rdata), .ext_data_err_i(ed_err)
  );

  ext_mem_model u_ext_instr_mem (
    .clk_i(clk), .rst_n_i(rst_n), .req_i(ei_req), .addr_i(ei_addr),
    .gnt_o(ei_gnt), .rvalid_o(ei_rvalid), .rdata_o(ei_rdata), .err_o(ei_err)
  );

  ext_mem_model u_ext_data_mem (
    .clk_i(clk), .rst_n_i(rst_n), .req_i(ed_req), .addr_i(ed_addr),
    .gnt_o(ed_gnt), .rvalid_o(ed_rvalid), .rdata_o(ed_rdata), .err_o(ed_err)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old_word,
                                                    logic [DATA_W-1:0] new_word,
                                                    logic [BE_W-1:0] be);
    logic [DATA_W-1:0] word;
    word = old_word;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) word[8*i +: 8] = new_word[8*i +: 8];
    end
    return word;
  endfunction

  // Expected answer at accept, shadow updated for writes
  function automatic resp_t expected_response(logic is_fetch, logic [ADDR_W-1:0] addr,
                                              logic we, logic [BE_W-1:0] be,
                                              logic [DATA_W-1:0] wdata);
    resp_t r;
    logic [TCM_IDX_W-1:0] idx;
    idx   = addr[TCM_IDX_W+1:2];
    r.rd  = !we;
    r.err = 1'b0;
    if (addr[31:12] == ITCM_START[31:12]) begin
      r.rdata = itcm_shadow[idx];
      if (we) itcm_shadow[idx] = merge_bytes(itcm_shadow[idx], wdata, be);
    end else if (!is_fetch && addr[31:12] == DTCM_START[31:12]) begin
      r.rdata = dtcm_shadow[idx];  // Fetch has no DTCM path
      if (we) dtcm_shadow[idx] = merge_bytes(dtcm_shadow[idx], wdata, be);
    end else begin
      r.rdata = {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
      r.err   = (addr[7:0] == 8'hEE);
    end
    return r;
  endfunction

  // Spread over the whole index range
  function automatic logic [ADDR_W-1:0] word_addr(logic [ADDR_W-1:0] base, int i);
    return base + 32'(i * 33 * 4);
  endfunction

  function automatic logic [ADDR_W-1:0] random_ext_addr(logic for_fetch);
    logic [ADDR_W-1:0] a;
    int unsigned pick;
    pick = $urandom_range(0, 7);
    a    = {8'h80, 24'($urandom)};
    if (pick == 0) a[7:0] = 8'hEE;                     // Error response
    if (pick == 1) a = {20'h70001, a[11:0]};           // Hole between TCMs
    if (pick == 2 && for_fetch) a = {20'h70002, a[11:0]};  // DTCM is external for fetch
    return a;
  endfunction

  ////////////////////////////////////////////////////////////
  // Monitor and comparison
  ////////////////////////////////////////////////////////////

  // Fetch first, so a same-cycle ITCM write is not seen by it
  always @(negedge clk) begin
    if (rst_n && fetch_req && fetch_gnt) begin
      fetch_q.push_back(expected_response(1'b1, fetch_addr, 1'b0, '0, '0));
    end
    if (rst_n && data_req && data_gnt) begin
      data_q.push_back(expected_response(1'b0, data_addr, data_we, data_be, data_wdata));
    end
    // External ports carry the host request unchanged
    if (rst_n && ei_req && ei_gnt) begin
      check_value("ext_instr_addr_o", ei_addr, fetch_addr);
    end
    if (rst_n && ed_req && ed_gnt) begin
      check_value("ext_data_addr_o", ed_addr, data_addr);
      check_value("ext_data_we_o", 32'(ed_we), 32'(data_we));
      check_value("ext_data_be_o", 32'(ed_be), 32'(data_be));
      check_value("ext_data_wdata_o", ed_wdata, data_wdata);
    end
  end

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  always @(negedge clk) begin
    resp_t exp_r;
    if (idle_check) begin
      check_value("fetch_rvalid_o", 32'(fetch_rvalid), 32'h0);
      check_value("data_rvalid_o", 32'(data_rvalid), 32'h0);
      check_value("ext_instr_req_o", 32'(ei_req), 32'h0);
      check_value("ext_data_req_o", 32'(ed_req), 32'h0);
    end else if (rst_n) begin
      if (fetch_rvalid && fetch_q.size() == 0) begin
        errors++;
        $display("Fetch response at %0t ns with nothing outstanding", $time);
      end else if (fetch_rvalid) begin
        exp_r = fetch_q.pop_front();
        if (exp_r.rd) check_value("fetch_rdata_o", fetch_rdata, exp_r.rdata);
        check_value("fetch_err_o", 32'(fetch_err), 32'(exp_r.err));
      end
      if (data_rvalid && data_q.size() == 0) begin
        errors++;
        $display("Data response at %0t ns with nothing outstanding", $time);
      end else if (data_rvalid) begin
        exp_r = data_q.pop_front();
        if (exp_r.rd) check_value("data_rdata_o", data_rdata, exp_r.rdata);
        check_value("data_err_o", 32'(data_err), 32'(exp_r.err));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Drivers, called on a rising edge and return on the accept edge
  ////////////////////////////////////////////////////////////

  task automatic issue_fetch(logic [ADDR_W-1:0] addr);
    logic granted;
    fetch_req  <= 1'b1;
    fetch_addr <= addr;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk);
      granted = fetch_gnt;
      @(posedge clk);
    end
  endtask

  task automatic issue_data(logic [ADDR_W-1:0] addr, logic we, logic [BE_W-1:0] be,
                            logic [DATA_W-1:0] wdata);
    logic granted;
    data_req   <= 1'b1;
    data_we    <= we;
    data_addr  <= addr;
    data_be    <= be;
    data_wdata <= wdata;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk);
      granted = data_gnt;
      @(posedge clk);
    end
  endtask

  // Drain both hosts, then one line for the test
  task automatic end_test(string name);
    fetch_req <= 1'b0;
    data_req  <= 1'b0;
    @(negedge clk);
    while (fetch_q.size() != 0 || data_q.size() != 0) @(negedge clk);
    @(posedge clk);
    $display("Test %s: %0d checks, %0d errors", name, checks - checks_at_start,
             errors - errors_at_start);
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic run_fetch_mix();
    for (int k = 0; k < N_MIXED; k++) begin
      if ($urandom_range(0, 3) == 0) begin
        fetch_req <= 1'b0;  // Idle cycle
        @(posedge clk);
      end
      if ($urandom_range(0, 3) != 0) begin
        issue_fetch(word_addr(ITCM_START, int'($urandom_range(0, N_WORDS - 1))));
      end else begin
        issue_fetch(random_ext_addr(1'b1));
      end
    end
    fetch_req <= 1'b0;
  endtask

  task automatic run_data_mix();
    int unsigned pick;
    int idx;
    for (int k = 0; k < N_MIXED; k++) begin
      if ($urandom_range(0, 3) == 0) begin
        data_req <= 1'b0;
        @(posedge clk);
      end
      pick = $urandom_range(0, 4);
      idx  = int'($urandom_range(0, N_WORDS - 1));
      case (pick)
        0:       issue_data(word_addr(ITCM_START, idx), 1'($urandom), 4'($urandom), $urandom);
        1, 2:    issue_data(word_addr(DTCM_START, idx), 1'($urandom), 4'($urandom), $urandom);
        default: issue_data(random_ext_addr(1'b0), 1'($urandom), 4'($urandom), $urandom);
      endcase
    end
    data_req <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'he9d8c88d));
    rst_n      <= 1'b0;
    fetch_req  <= 1'b0;
    fetch_addr <= '0;
    data_req   <= 1'b0;
    data_we    <= 1'b0;
    data_addr  <= '0;
    data_be    <= '0;
    data_wdata <= '0;
    idle_check = 1'b1;

    // Reset state, also two cycles past release
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    idle_check = 1'b0;
    end_test("reset_state");

    // ITCM written on the data port, read back on both ports
    for (int i = 0; i < N_WORDS; i++) issue_data(word_addr(ITCM_START, i), 1'b1, 4'hF, $urandom);
    for (int i = 0; i < N_WORDS; i++) issue_data(word_addr(ITCM_START, i), 1'b0, 4'hF, '0);
    data_req <= 1'b0;
    for (int i = 0; i < N_WORDS; i++) issue_fetch(word_addr(ITCM_START, i));
    end_test("shared_itcm");

    // DTCM full fill, partial writes, read back
    for (int i = 0; i < N_WORDS; i++) issue_data(word_addr(DTCM_START, i), 1'b1, 4'hF, $urandom);
    for (int k = 0; k < N_PARTIAL; k++) begin
      issue_data(word_addr(DTCM_START, int'($urandom_range(0, N_WORDS - 1))), 1'b1,
                 4'($urandom), $urandom);
    end
    for (int i = 0; i < N_WORDS; i++) issue_data(word_addr(DTCM_START, i), 1'b0, 4'hF, '0);
    end_test("dtcm_byte_enables");

    for (int k = 0; k < N_EXT; k++) issue_fetch(random_ext_addr(1'b1));
    fetch_req <= 1'b0;
    for (int k = 0; k < N_EXT; k++) begin
      issue_data(random_ext_addr(1'b0), 1'($urandom), 4'($urandom), $urandom);
    end
    end_test("external");

    // Both hosts at once
    fork
      run_fetch_mix();
      run_data_mix();
    join
    end_test("mixed_order");

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* tb.f */
hdl/tcm_pkg.sv
hdl/instr_router.sv
hdl/data_router.sv
hdl/itcm.sv
hdl/dtcm.sv
hdl/tcm_subsystem.sv
verif/ext_mem_model.sv
verif/tb_tcm_subsystem.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, status follows the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_tcm_subsystem -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
